/* logic/axi_mem_defs.svh */
`ifndef AXI_MEM_DEFS_SVH
`define AXI_MEM_DEFS_SVH

////////////////////
// Bus widths
////////////////////

// Transaction id on AW, B, AR and R
`define AXI_ID_WIDTH 4

////////////////////
// Memory geometry
////////////////////

// Number of 32-bit words
`define MEM_DEPTH 1024
// log2 of MEM_DEPTH, word index taken from address bits 11:2
`define MEM_INDEX_BITS 10
// Loaded into every word at time zero
`define MEM_INIT_VALUE 32'h0000_0000

`endif

/* logic/axi_mem_pkg.sv */
`include "axi_mem_defs.svh"

package axi_mem_pkg;

	// Word index into the RAM
	// Addresses past the depth wrap since only the low bits are kept
	typedef logic [`MEM_INDEX_BITS-1:0] mem_index_t;

	// One 32-bit memory word
	// Seen whole on the bus, lane by lane in the RAM
	typedef union packed {
		logic [31:0]     word;
		// Lane 0 is the lowest byte
		logic [3:0][7:0] lanes;
	} axi_word_u;

endpackage

/* logic/mem_wr_if.sv */
`timescale 1ns/1ps

// Internal byte-lane write port, one beat per en strobe
interface mem_wr_if
	import axi_mem_pkg::*;
();
	logic       en;
	mem_index_t index;
	logic [3:0] strb;
	axi_word_u  data;

	// Write engine side
	modport wr_master (
		output en, index, strb, data
	);

	// RAM side
	modport wr_slave (
		input en, index, strb, data
	);
endinterface

/* logic/byte_lane_ram.sv */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module byte_lane_ram
	import axi_mem_pkg::*;
(
	input  logic        s_axi_aclk,
	mem_wr_if.wr_slave  wr,
	input  mem_index_t  rd_index,
	output axi_word_u   rd_data
);

	localparam axi_word_u init_word = `MEM_INIT_VALUE;

	// One byte per lane and index, gathered on the read side
	wire [7:0] lane_rd [4];

	////////////////////
	// Byte lanes
	////////////////////

	for (genvar l = 0; l < 4; l++) begin : g_lane
		logic [7:0] mem [`MEM_DEPTH];

		// Fill with the matching byte of the init word
		initial begin
			for (int i = 0; i < `MEM_DEPTH; i++) begin
				mem[i] = init_word.lanes[l];
			end
		end

		// Lane written only when its strobe bit is set
		always @(posedge s_axi_aclk) begin
			if (wr.en && wr.strb[l]) begin
				mem[wr.index] <= wr.data.lanes[l];
			end
		end

		assign lane_rd[l] = mem[rd_index];
	end

	////////////////////
	// Read port
	////////////////////

	// Pure combinational, a same-cycle write shows up one edge later
	always_comb begin
		for (int l = 0; l < 4; l++) begin
			rd_data.lanes[l] = lane_rd[l];
		end
	end

endmodule

/* logic/axi_write_engine.sv */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_write_engine
	import axi_mem_pkg::*;
(
	input  logic                     s_axi_aclk,
	input  logic                     s_axi_aresetn,
	// Write address
	input  logic [`AXI_ID_WIDTH-1:0] awid,
	input  logic [31:0]              awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	// Write data
	input  axi_word_u                wdata,
	input  logic [3:0]               wstrb,
	input  logic                     wlast,
	input  logic                     wvalid,
	output logic                     wready,
	// Write response
	output logic [`AXI_ID_WIDTH-1:0] bid,
	output logic                     bvalid,
	input  logic                     bready,
	// To the RAM
	mem_wr_if.wr_master              mem
);

	logic                     aw_fire;
	logic                     w_fire;
	logic                     b_fire;
	logic [`AXI_ID_WIDTH-1:0] wr_id;
	mem_index_t               wr_index;

	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	assign b_fire  = bvalid && bready;

	////////////////////
	// Phase control
	////////////////////

	// Idle while awready, data while wready, respond while bvalid
	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			awready <= 1'b1;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			if (aw_fire) begin
				awready <= 1'b0;
			end else if (b_fire) begin
				awready <= 1'b1;
			end

			// Burst length comes from wlast only
			if (aw_fire) begin
				wready <= 1'b1;
			end else if (w_fire && wlast) begin
				wready <= 1'b0;
			end

			if (w_fire && wlast) begin
				bvalid <= 1'b1;
			end else if (b_fire) begin
				bvalid <= 1'b0;
			end
		end
	end

	////////////////////
	// Burst address and id
	////////////////////

	always_ff @(posedge s_axi_aclk) begin
		if (aw_fire) begin
			wr_index <= awaddr[`MEM_INDEX_BITS+1:2];
			wr_id    <= awid;
		end else if (w_fire) begin
			// INCR with a 4-byte step
			wr_index <= wr_index + 1'b1;
		end
	end

	assign bid = wr_id;

	// Every accepted beat hits the RAM at the same edge
	assign mem.en    = w_fire;
	assign mem.index = wr_index;
	assign mem.strb  = wstrb;
	assign mem.data  = wdata;

endmodule

/* logic/axi_read_engine.sv */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_read_engine
	import axi_mem_pkg::*;
(
	input  logic                     s_axi_aclk,
	input  logic                     s_axi_aresetn,
	// Read address
	input  logic [`AXI_ID_WIDTH-1:0] arid,
	input  logic [31:0]              araddr,
	input  logic [7:0]               arlen,
	input  logic                     arvalid,
	output logic                     arready,
	// Read data
	output logic [`AXI_ID_WIDTH-1:0] rid,
	output axi_word_u                rdata,
	output logic                     rlast,
	output logic                     rvalid,
	input  logic                     rready,
	// From the RAM
	output mem_index_t               rd_index,
	input  axi_word_u                rd_data
);

	logic       ar_fire;
	logic       r_fire;
	logic       beat_load;
	logic [7:0] rd_len;
	logic [7:0] rd_beat;
	mem_index_t rd_next;

	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	// New beat on AR or on any taken beat except the last
	assign beat_load = ar_fire || (r_fire && !rlast);

	// First beat straight from araddr, later beats from the running index
	assign rd_index = ar_fire ? araddr[`MEM_INDEX_BITS+1:2] : rd_next;

	////////////////////
	// Handshake and beat count
	////////////////////

	always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
		if (!s_axi_aresetn) begin
			arready <= 1'b1;
			rvalid  <= 1'b0;
			rlast   <= 1'b0;
			rd_beat <= '0;
		end else if (ar_fire) begin
			arready <= 1'b0;
			rvalid  <= 1'b1;
			rlast   <= (arlen == 8'd0);
			rd_beat <= '0;
		end else if (r_fire) begin
			if (rlast) begin
				// Burst done, AR channel reopens next cycle
				arready <= 1'b1;
				rvalid  <= 1'b0;
				rlast   <= 1'b0;
			end else begin
				rd_beat <= rd_beat + 8'd1;
				rlast   <= (rd_beat + 8'd1 == rd_len);
			end
		end
	end

	////////////////////
	// Beat payload
	////////////////////

	// Held unchanged while rready is low
	always_ff @(posedge s_axi_aclk) begin
		if (ar_fire) begin
			rid    <= arid;
			rd_len <= arlen;
		end
		if (beat_load) begin
			rdata   <= rd_data;
			rd_next <= rd_index + 1'b1;
		end
	end

endmodule

/* logic/axi_memory_model.sv */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module axi_memory_model
	import axi_mem_pkg::*;
(
	input  logic                     s_axi_aclk,
	input  logic                     s_axi_aresetn,
	// Write address
	input  logic [`AXI_ID_WIDTH-1:0] s_axi_awid,
	input  logic [31:0]              s_axi_awaddr,
	input  logic [7:0]               s_axi_awlen,
	input  logic                     s_axi_awvalid,
	output logic                     s_axi_awready,
	// Write data
	input  logic [31:0]              s_axi_wdata,
	input  logic [3:0]               s_axi_wstrb,
	input  logic                     s_axi_wlast,
	input  logic                     s_axi_wvalid,
	output logic                     s_axi_wready,
	// Write response
	output logic [`AXI_ID_WIDTH-1:0] s_axi_bid,
	output logic [1:0]               s_axi_bresp,
	output logic                     s_axi_bvalid,
	input  logic                     s_axi_bready,
	// Read address
	input  logic [`AXI_ID_WIDTH-1:0] s_axi_arid,
	input  logic [31:0]              s_axi_araddr,
	input  logic [7:0]               s_axi_arlen,
	input  logic                     s_axi_arvalid,
	output logic                     s_axi_arready,
	// Read data
	output logic [`AXI_ID_WIDTH-1:0] s_axi_rid,
	output logic [31:0]              s_axi_rdata,
	output logic [1:0]               s_axi_rresp,
	output logic                     s_axi_rlast,
	output logic                     s_axi_rvalid,
	input  logic                     s_axi_rready
);

	axi_word_u  wdata_u;
	axi_word_u  rdata_u;
	axi_word_u  rd_data;
	mem_index_t rd_index;

	mem_wr_if wr_port ();

	////////////////////
	// Bus side
	////////////////////

	assign wdata_u.word = s_axi_wdata;
	assign s_axi_rdata  = rdata_u.word;

	// Always OKAY
	assign s_axi_bresp = 2'b00;
	assign s_axi_rresp = 2'b00;

	// s_axi_awlen is left unused, wlast closes the write burst

	////////////////////
	// Engines and storage
	////////////////////

	axi_write_engine u_wr (
		.s_axi_aclk    (s_axi_aclk),
		.s_axi_aresetn (s_axi_aresetn),
		.awid          (s_axi_awid),
		.awaddr        (s_axi_awaddr),
		.awvalid       (s_axi_awvalid),
		.awready       (s_axi_awready),
		.wdata         (wdata_u),
		.wstrb         (s_axi_wstrb),
		.wlast         (s_axi_wlast),
		.wvalid        (s_axi_wvalid),
		.wready        (s_axi_wready),
		.bid           (s_axi_bid),
		.bvalid        (s_axi_bvalid),
		.bready        (s_axi_bready),
		.mem           (wr_port.wr_master)
	);

	axi_read_engine u_rd (
		.s_axi_aclk    (s_axi_aclk),
		.s_axi_aresetn (s_axi_aresetn),
		.arid          (s_axi_arid),
		.araddr        (s_axi_araddr),
		.arlen         (s_axi_arlen),
		.arvalid       (s_axi_arvalid),
		.arready       (s_axi_arready),
		.rid           (s_axi_rid),
		.rdata         (rdata_u),
		.rlast         (s_axi_rlast),
		.rvalid        (s_axi_rvalid),
		.rready        (s_axi_rready),
		.rd_index      (rd_index),
		.rd_data       (rd_data)
	);

	byte_lane_ram u_ram (
		.s_axi_aclk (s_axi_aclk),
		.wr         (wr_port.wr_slave),
		.rd_index   (rd_index),
		.rd_data    (rd_data)
	);

endmodule

/* tb/tb_axi_memory_model.sv */
`timescale 1ns/1ps
`include "axi_mem_defs.svh"

module tb_axi_memory_model
	import axi_mem_pkg::*;
();

	// Upper bound for the whole run in clock cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic                     s_axi_aclk;
	logic                     s_axi_aresetn;
	logic [`AXI_ID_WIDTH-1:0] s_axi_awid;
	logic [31:0]              s_axi_awaddr;
	logic [7:0]               s_axi_awlen;
	logic                     s_axi_awvalid;
	logic                     s_axi_awready;
	logic [31:0]              s_axi_wdata;
	logic [3:0]               s_axi_wstrb;
	logic                     s_axi_wlast;
	logic                     s_axi_wvalid;
	logic                     s_axi_wready;
	logic [`AXI_ID_WIDTH-1:0] s_axi_bid;
	logic [1:0]               s_axi_bresp;
	logic                     s_axi_bvalid;
	logic                     s_axi_bready;
	logic [`AXI_ID_WIDTH-1:0] s_axi_arid;
	logic [31:0]              s_axi_araddr;
	logic [7:0]               s_axi_arlen;
	logic                     s_axi_arvalid;
	logic                     s_axi_arready;
	logic [`AXI_ID_WIDTH-1:0] s_axi_rid;
	logic [31:0]              s_axi_rdata;
	logic [1:0]               s_axi_rresp;
	logic                     s_axi_rlast;
	logic                     s_axi_rvalid;
	logic                     s_axi_rready;

	// Reference memory and write beat buffer
	axi_word_u model [`MEM_DEPTH];
	axi_word_u wbuf [32];

	int word_errs  = 0;
	int id_errs    = 0;
	int flag_errs  = 0;
	int proto_errs = 0;
	int cycle_cnt  = 0;

	axi_memory_model dut0 (.*);

	initial begin
		s_axi_aclk = 1'b0;
		forever begin
			#50 s_axi_aclk = ~s_axi_aclk;
		end
	end

	always @(posedge s_axi_aclk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	////////////////////
	// Checks
	////////////////////

	task automatic check_word(input axi_word_u got, input axi_word_u exp, input string what);
		if (got.word !== exp.word) begin
			$display("Fail %0t: %s got %h expected %h", $time, what, got.word, exp.word);
			word_errs++;
		end
	endtask

	task automatic check_id(input logic [`AXI_ID_WIDTH-1:0] got,
			input logic [`AXI_ID_WIDTH-1:0] exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
			id_errs++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
			flag_errs++;
		end
	endtask

	////////////////////
	// Bus tasks
	////////////////////

	// Writes wbuf[0..len-1] from addr, then holds bready low for stall cycles
	task automatic axi_write_burst(input logic [31:0] addr, input logic [`AXI_ID_WIDTH-1:0] id,
			input int len, input logic [3:0] strb, input int stall);
		mem_index_t idx;
		idx           = addr[`MEM_INDEX_BITS+1:2];
		s_axi_awaddr  = addr;
		s_axi_awid    = id;
		s_axi_awlen   = 8'(len - 1);
		s_axi_awvalid = 1'b1;
		@(negedge s_axi_aclk);
		while (!s_axi_awready) begin
			@(negedge s_axi_aclk);
		end
		@(posedge s_axi_aclk);
		#1;
		s_axi_awvalid = 1'b0;
		for (int i = 0; i < len; i++) begin
			s_axi_wdata  = wbuf[i].word;
			s_axi_wstrb  = strb;
			s_axi_wlast  = (i == len - 1);
			s_axi_wvalid = 1'b1;
			@(negedge s_axi_aclk);
			check_flag(s_axi_wready, 1'b1, "wready during burst");
			while (!s_axi_wready) begin
				@(negedge s_axi_aclk);
			end
			// Beat lands at the coming edge
			for (int l = 0; l < 4; l++) begin
				if (strb[l]) begin
					model[idx].lanes[l] = wbuf[i].lanes[l];
				end
			end
			idx = idx + 1'b1;
			@(posedge s_axi_aclk);
			#1;
		end
		s_axi_wvalid = 1'b0;
		s_axi_wlast  = 1'b0;
		for (int k = 0; k < stall; k++) begin
			@(negedge s_axi_aclk);
			check_flag(s_axi_bvalid, 1'b1, "bvalid during stall");
			check_id(s_axi_bid, id, "bid during stall");
			check_flag(s_axi_awready, 1'b0, "awready before B done");
			@(posedge s_axi_aclk);
			#1;
		end
		s_axi_bready = 1'b1;
		@(negedge s_axi_aclk);
		check_flag(s_axi_wready, 1'b0, "wready after wlast");
		for (int n = 0; n < 16 && !s_axi_bvalid; n++) begin
			@(negedge s_axi_aclk);
		end
		if (!s_axi_bvalid) begin
			$display("Write response never arrived for id %0h", id);
			proto_errs++;
		end else begin
			check_id(s_axi_bid, id, "bid");
			check_flag(s_axi_bresp == 2'b00, 1'b1, "bresp OKAY");
		end
		@(posedge s_axi_aclk);
		#1;
		s_axi_bready = 1'b0;
		check_flag(s_axi_bvalid, 1'b0, "bvalid after B");
		check_flag(s_axi_awready, 1'b1, "awready after B");
	endtask

	// Reads len beats from addr and compares against the model
	task automatic axi_read_burst(input logic [31:0] addr, input logic [`AXI_ID_WIDTH-1:0] id,
			input int len, input bit rand_ready);
		mem_index_t  idx;
		int          beat;
		logic [31:0] rnd;
		idx           = addr[`MEM_INDEX_BITS+1:2];
		beat          = 0;
		s_axi_araddr  = addr;
		s_axi_arid    = id;
		s_axi_arlen   = 8'(len - 1);
		s_axi_arvalid = 1'b1;
		@(negedge s_axi_aclk);
		while (!s_axi_arready) begin
			@(negedge s_axi_aclk);
		end
		@(posedge s_axi_aclk);
		#1;
		s_axi_arvalid = 1'b0;
		while (beat < len) begin
			rnd          = $urandom;
			s_axi_rready = rand_ready ? rnd[0] : 1'b1;
			@(negedge s_axi_aclk);
			if (!s_axi_rvalid) begin
				$display("Read data missing: rvalid low before beat %0d of %0d", beat, len);
				proto_errs++;
				beat = len;
			end else begin
				check_id(s_axi_rid, id, "rid");
				if (s_axi_rready) begin
					check_word(s_axi_rdata, model[idx], "rdata");
					check_flag(s_axi_rlast, beat == len - 1, "rlast");
					check_flag(s_axi_rresp == 2'b00, 1'b1, "rresp OKAY");
					idx = idx + 1'b1;
					beat++;
				end
			end
			@(posedge s_axi_aclk);
			#1;
		end
		s_axi_rready = 1'b0;
		@(negedge s_axi_aclk);
		check_flag(s_axi_rvalid, 1'b0, "rvalid after last beat");
		check_flag(s_axi_arready, 1'b1, "arready after last beat");
		@(posedge s_axi_aclk);
		#1;
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic fill_random(input int len);
		for (int i = 0; i < len; i++) begin
			wbuf[i].word = $urandom;
		end
	endtask

	task automatic reset_fill();
		logic [31:0] rnd;
		rnd = $urandom;
		axi_read_burst({20'h0, rnd[11:2], 2'b00}, 4'h3, 1, 1'b0);
	endtask

	task automatic incr_bursts();
		fill_random(16);
		axi_write_burst(32'h0000_0100, 4'h5, 16, 4'hf, 0);
		axi_read_burst(32'h0000_0100, 4'h9, 16, 1'b0);
	endtask

	// Two half writes to one word, merged lane by lane
	task automatic byte_strobes();
		fill_random(1);
		axi_write_burst(32'h0000_0040, 4'h1, 1, 4'b0101, 0);
		fill_random(1);
		axi_write_burst(32'h0000_0040, 4'h2, 1, 4'b1010, 0);
		axi_read_burst(32'h0000_0040, 4'h4, 1, 1'b0);
	endtask

	task automatic read_backpressure();
		fill_random(32);
		axi_write_burst(32'h0000_0800, 4'hb, 32, 4'hf, 0);
		axi_read_burst(32'h0000_0800, 4'hc, 32, 1'b1);
	endtask

	task automatic bresp_hold();
		fill_random(4);
		axi_write_burst(32'h0000_0300, 4'ha, 4, 4'hf, 5);
		axi_read_burst(32'h0000_0300, 4'hd, 4, 1'b0);
	endtask

	task automatic address_wrap();
		fill_random(1);
		axi_write_burst(32'(4 * `MEM_DEPTH + 8), 4'h6, 1, 4'hf, 0);
		axi_read_burst(32'h0000_0008, 4'h7, 1, 1'b0);
	endtask

	initial begin
		void'($urandom(32'h8eccfe3f));
		s_axi_aresetn = 1'b0;
		s_axi_awid    = '0;
		s_axi_awaddr  = '0;
		s_axi_awlen   = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wlast   = 1'b0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_arid    = '0;
		s_axi_araddr  = '0;
		s_axi_arlen   = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;
		for (int i = 0; i < `MEM_DEPTH; i++) begin
			model[i].word = `MEM_INIT_VALUE;
		end
		repeat (10) @(posedge s_axi_aclk);
		#1;
		s_axi_aresetn = 1'b1;

		reset_fill();
		incr_bursts();
		byte_strobes();
		read_backpressure();
		bresp_hold();
		address_wrap();

		repeat (2) @(posedge s_axi_aclk);
		$display("Errors: word %0d, id %0d, flag %0d, protocol %0d",
			word_errs, id_errs, flag_errs, proto_errs);
		if (word_errs + id_errs + flag_errs + proto_errs == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+logic
logic/axi_mem_pkg.sv
logic/mem_wr_if.sv
logic/byte_lane_ram.sv
logic/axi_write_engine.sv
logic/axi_read_engine.sv
logic/axi_memory_model.sv
tb/tb_axi_memory_model.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_axi_memory_model \
	-o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "Build or simulation error, see build.log and sim.log"; exit 1; }

grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
